// File: saturn_dec_macros.svh
/*
 * Saturn decoder widths
 * nibble, address, immediate buffer and counter sizes shared by the
 * decoder RTL and its testbench
 */

`ifndef SATURN_DEC_MACROS_SVH
`define SATURN_DEC_MACROS_SVH

// one opcode nibble
`define SAT_NIBBLE_W 4

// program counter
`define SAT_ADDR_W 20

// immediate buffer of up to 16 digits for load C hex
`define SAT_IMM_NIBBLES 16
`define SAT_IMM_W (`SAT_IMM_NIBBLES * `SAT_NIBBLE_W)

// nibble counter wide enough to hold SAT_IMM_NIBBLES
`define SAT_CNT_W 5

`endif

// File: saturn_dec_pkg.sv
/*
 * Saturn decoder types
 * operation encodings, sequencer states and the packed result layout
 */

`include "saturn_dec_macros.svh"

package saturn_dec_pkg;

  typedef enum logic [3:0] {
    ALU_NONE     = 4'h0,
    ALU_COPY     = 4'h1,
    ALU_EXCH     = 4'h2,
    ALU_ZERO     = 4'h3,
    ALU_INC      = 4'h4,
    ALU_DEC      = 4'h5,
    ALU_JMP_REL2 = 4'h6,
    ALU_JMP_REL3 = 4'h7
  } alu_op_e;

  typedef enum logic [2:0] {
    INS_NONE     = 3'd0,
    INS_RTN      = 3'd1,
    INS_SET_MODE = 3'd2,
    INS_ALU      = 3'd3,
    INS_SET_P    = 3'd4,
    INS_LOAD_C   = 3'd5,
    INS_JUMP     = 3'd6
  } ins_kind_e;

  typedef enum logic [2:0] {
    ST_FIRST    = 3'd0,
    ST_BLK_0X   = 3'd1,
    ST_LOAD_LEN = 3'd2,
    ST_COLLECT  = 3'd3,
    ST_HALT     = 3'd4
  } dec_state_e;

  // return stack and carry handling
  typedef struct packed {
    logic push;
    logic pop;
    logic set_xm;
    logic set_carry;
    logic carry_val;
    logic test_carry;
    logic en_intr;
  } flow_ctl_t;

  typedef struct packed {
    ins_kind_e kind;
    alu_op_e   alu_op;
    flow_ctl_t flow;
    logic      mode_dec;
  } op_fields_t;

  typedef struct packed {
    logic [`SAT_CNT_W-1:0] imm_len;
    logic [`SAT_IMM_W-1:0] imm_value;
  } imm_fields_t;

  typedef struct packed {
    logic [`SAT_ADDR_W-1:0] ins_addr;
    op_fields_t             op;
    imm_fields_t            imm;
  } dec_result_t;

endpackage

// File: dec_sequencer.sv
/*
 * Decoder sequencer
 * nibble-level FSM that follows each instruction, captures its start
 * address, starts immediate collection and flags completion or error
 */

`timescale 1ns/1ps

`include "saturn_dec_macros.svh"

module dec_sequencer import saturn_dec_pkg::*; (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_en_dec,
  input  logic                     i_stalled,
  input  logic [`SAT_ADDR_W-1:0]   i_pc,
  input  logic [`SAT_NIBBLE_W-1:0] i_nibble,
  input  logic                     i_imm_last,
  output logic                     o_take,
  output dec_state_e               o_state,
  output logic                     o_imm_start,
  output logic [`SAT_CNT_W-1:0]    o_imm_len,
  output logic [`SAT_ADDR_W-1:0]   o_ins_addr,
  output logic                     o_ins_decoded,
  output logic                     o_dec_error
);

  // nothing moves while stalled, disabled or halted
  assign o_take = i_en_dec && !i_stalled && (o_state != ST_HALT);

  // immediate length is known on the first nibble, or on the
  // length nibble of load C hex
  always_comb begin
    o_imm_start = 1'b0;
    o_imm_len   = '0;
    case (o_state)
      ST_FIRST: begin
        case (i_nibble)
          4'h2: begin
            o_imm_start = o_take;
            o_imm_len   = `SAT_CNT_W'(1);
          end
          4'h4, 4'h5: begin
            o_imm_start = o_take;
            o_imm_len   = `SAT_CNT_W'(2);
          end
          4'h6, 4'h7: begin
            o_imm_start = o_take;
            o_imm_len   = `SAT_CNT_W'(3);
          end
          default: ;
        endcase
      end
      ST_LOAD_LEN: begin
        o_imm_start = o_take;
        o_imm_len   = {1'b0, i_nibble} + 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_state       <= ST_FIRST;
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;
    end else begin
      o_ins_decoded <= 1'b0;
      if (o_take) begin
        case (o_state)
          ST_FIRST: begin
            case (i_nibble)
              4'h0:                   o_state <= ST_BLK_0X;
              4'h3:                   o_state <= ST_LOAD_LEN;
              4'h2, 4'h4, 4'h5,
              4'h6, 4'h7:             o_state <= ST_COLLECT;
              default: begin
                o_state     <= ST_HALT;
                o_dec_error <= 1'b1;
              end
            endcase
          end
          ST_BLK_0X: begin
            // 0E is left undecoded and raises the error
            if (i_nibble == 4'hE) begin
              o_state     <= ST_HALT;
              o_dec_error <= 1'b1;
            end else begin
              o_state       <= ST_FIRST;
              o_ins_decoded <= 1'b1;
            end
          end
          ST_LOAD_LEN: o_state <= ST_COLLECT;
          ST_COLLECT: begin
            if (i_imm_last) begin
              o_state       <= ST_FIRST;
              o_ins_decoded <= 1'b1;
            end
          end
          default: o_state <= ST_HALT;
        endcase
      end
    end
  end

  // start address of the instruction
  always_ff @(posedge i_clk) begin
    if (o_take && (o_state == ST_FIRST)) begin
      o_ins_addr <= i_pc;
    end
  end

endmodule

// File: dec_op_gen.sv
/*
 * Operation generator
 * decodes instruction kind, ALU operation, flow flags and mode
 * from the first and second opcode nibbles
 */

`timescale 1ns/1ps

`include "saturn_dec_macros.svh"

module dec_op_gen import saturn_dec_pkg::*; (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_take,
  input  dec_state_e               i_state,
  input  logic [`SAT_NIBBLE_W-1:0] i_nibble,
  output op_fields_t               o_op
);

  op_fields_t op_next;

  always_comb begin
    op_next = o_op;
    if (i_state == ST_FIRST) begin
      // new instruction starts from a clean set
      op_next = '0;
      case (i_nibble)
        4'h2: begin
          op_next.kind   = INS_SET_P;
          op_next.alu_op = ALU_COPY;
        end
        4'h3: begin
          op_next.kind   = INS_LOAD_C;
          op_next.alu_op = ALU_COPY;
        end
        4'h4, 4'h5: begin
          // GOC / GONC
          op_next.kind            = INS_JUMP;
          op_next.alu_op          = ALU_JMP_REL2;
          op_next.flow.test_carry = 1'b1;
          op_next.flow.carry_val  = !i_nibble[0];
        end
        4'h6, 4'h7: begin
          // GOSUB pushes the return address
          op_next.kind      = INS_JUMP;
          op_next.alu_op    = ALU_JMP_REL3;
          op_next.flow.push = i_nibble[0];
        end
        default: ;
      endcase
    end else if (i_state == ST_BLK_0X) begin
      case (i_nibble)
        4'h0, 4'h1, 4'h2, 4'h3, 4'hF: begin
          // RTNSXM RTN RTNSC RTNCC RTI
          op_next.kind           = INS_RTN;
          op_next.flow.pop       = 1'b1;
          op_next.flow.set_xm    = (i_nibble == 4'h0);
          op_next.flow.set_carry = !i_nibble[3] && i_nibble[1];
          op_next.flow.carry_val = i_nibble[1] && !i_nibble[0] && !i_nibble[3];
          op_next.flow.en_intr   = i_nibble[3];
        end
        4'h4, 4'h5: begin
          // SETHEX / SETDEC
          op_next.kind     = INS_SET_MODE;
          op_next.mode_dec = i_nibble[0];
        end
        4'h6, 4'h7: begin
          // RSTK=C and C=RSTK
          op_next.kind      = INS_ALU;
          op_next.alu_op    = ALU_COPY;
          op_next.flow.push = !i_nibble[0];
          op_next.flow.pop  = i_nibble[0];
        end
        4'h8: begin
          op_next.kind   = INS_ALU;
          op_next.alu_op = ALU_ZERO;
        end
        4'h9, 4'hA: begin
          op_next.kind   = INS_ALU;
          op_next.alu_op = ALU_COPY;
        end
        4'hB: begin
          op_next.kind   = INS_ALU;
          op_next.alu_op = ALU_EXCH;
        end
        4'hC, 4'hD: begin
          op_next.kind   = INS_ALU;
          op_next.alu_op = i_nibble[0] ? ALU_DEC : ALU_INC;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_op <= '0;
    end else if (i_take) begin
      o_op <= op_next;
    end
  end

endmodule

// File: imm_collector.sv
/*
 * Immediate collector
 * packs immediate and offset nibbles low first and flags the last one
 */

`timescale 1ns/1ps

`include "saturn_dec_macros.svh"

module imm_collector import saturn_dec_pkg::*; (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_take,
  input  logic                     i_imm_start,
  input  logic [`SAT_CNT_W-1:0]    i_imm_len,
  input  logic [`SAT_NIBBLE_W-1:0] i_nibble,
  output logic                     o_imm_last,
  output imm_fields_t              o_imm
);

  logic                  active;
  logic [`SAT_CNT_W-1:0] pos;
  logic [`SAT_CNT_W-1:0] pos_next;

  assign pos_next   = pos + 1'b1;
  assign o_imm_last = active && (pos_next == o_imm.imm_len);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      active        <= 1'b0;
      pos           <= '0;
      o_imm.imm_len <= '0;
    end else if (i_imm_start) begin
      active        <= 1'b1;
      pos           <= '0;
      o_imm.imm_len <= i_imm_len;
    end else if (i_take) begin
      if (active) begin
        pos    <= pos_next;
        active <= !o_imm_last;
      end else begin
        // opcode nibble of an instruction without immediate
        o_imm.imm_len <= '0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_imm_start || (i_take && !active)) begin
      o_imm.imm_value <= '0;
    end else if (i_take) begin
      o_imm.imm_value[pos*`SAT_NIBBLE_W +: `SAT_NIBBLE_W] <= i_nibble;
    end
  end

endmodule

// File: saturn_decoder.sv
/*
 * Saturn instruction decoder
 * takes one opcode nibble per accepted cycle and reports the decoded
 * instruction as a packed result with a one-cycle strobe
 */

`timescale 1ns/1ps

`include "saturn_dec_macros.svh"

module saturn_decoder import saturn_dec_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_en_dec,
  input  logic                    i_stalled,
  input  logic [`SAT_ADDR_W-1:0]  i_pc,
  input  logic [`SAT_NIBBLE_W-1:0] i_nibble,
  output logic                    o_ins_decoded,
  output logic                    o_dec_error,
  output dec_result_t             o_result
);

  logic                   take;
  dec_state_e             state;
  logic                   imm_start;
  logic [`SAT_CNT_W-1:0]  imm_len;
  logic                   imm_last;
  logic [`SAT_ADDR_W-1:0] ins_addr;
  op_fields_t             op_fields;
  imm_fields_t            imm_fields;

  // instruction progress, start address and error
  dec_sequencer u_sequencer (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_en_dec      (i_en_dec),
    .i_stalled     (i_stalled),
    .i_pc          (i_pc),
    .i_nibble      (i_nibble),
    .i_imm_last    (imm_last),
    .o_take        (take),
    .o_state       (state),
    .o_imm_start   (imm_start),
    .o_imm_len     (imm_len),
    .o_ins_addr    (ins_addr),
    .o_ins_decoded (o_ins_decoded),
    .o_dec_error   (o_dec_error)
  );

  dec_op_gen u_op_gen (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_take   (take),
    .i_state  (state),
    .i_nibble (i_nibble),
    .o_op     (op_fields)
  );

  // immediates and jump offsets
  imm_collector u_imm (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_take      (take),
    .i_imm_start (imm_start),
    .i_imm_len   (imm_len),
    .i_nibble    (i_nibble),
    .o_imm_last  (imm_last),
    .o_imm       (imm_fields)
  );

  assign o_result = '{ins_addr: ins_addr, op: op_fields, imm: imm_fields};

endmodule

// File: tb_saturn_decoder_tasks.svh
/*
 * Saturn decoder testbench tasks
 * nibble drivers, compare tasks and the directed tests
 */

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "decoder test stopped");
  endtask

  task automatic check_result(input dec_result_t got, input dec_result_t exp,
                              input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0d ns: %s result %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_error(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0d ns: %s, o_dec_error %b, expected %b",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_strobe(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0d ns: %s, o_ins_decoded %b, expected %b",
                                  $time, what, got, exp));
    end
  endtask

  task automatic apply_reset();
    reset   = 1'b1;
    en_dec  = 1'b0;
    stalled = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  // present one nibble for a single accepting cycle
  task automatic accept_nibble(input logic [`SAT_NIBBLE_W-1:0] nib,
                               input logic [`SAT_ADDR_W-1:0] addr);
    en_dec  = 1'b1;
    stalled = 1'b0;
    nibble  = nib;
    pc      = addr;
    @(posedge clk);
    #1;
    en_dec = 1'b0;
    nibble = 4'($urandom_range(15, 0));
  endtask

  // stalled or disabled cycles with junk on the nibble bus
  task automatic insert_idle();
    repeat ($urandom_range(MAX_IDLE, 0)) begin
      en_dec  = 1'($urandom_range(1, 0));
      stalled = en_dec ? 1'b1 : 1'($urandom_range(1, 0));
      nibble  = 4'($urandom_range(15, 0));
      @(posedge clk);
      #1;
      check_strobe(ins_decoded, 1'b0, "strobe during an idle cycle");
    end
    en_dec  = 1'b0;
    stalled = 1'b0;
  endtask

  task automatic run_instruction(input nib_q_t nibs);
    logic [`SAT_ADDR_W-1:0] addr;
    dec_result_t exp;
    int waited;
    addr = `SAT_ADDR_W'($urandom);
    exp  = expected_result(addr, nibs);
    foreach (nibs[i]) begin
      if (use_stalls) begin
        insert_idle();
      end
      accept_nibble(nibs[i], addr + `SAT_ADDR_W'(i));
      if (i < nibs.size() - 1) begin
        check_strobe(ins_decoded, 1'b0, "strobe before the last nibble");
      end
    end
    waited = 0;
    while (!ins_decoded && waited < DONE_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!ins_decoded) begin
      stop_with_failure("the decoder never reported the instruction as decoded");
    end
    check_result(result, exp, "decoded");
    check_error(dec_error, 1'b0, "valid instruction");
    @(posedge clk);
    #1;
    check_strobe(ins_decoded, 1'b0, "strobe longer than one cycle");
    check_result(result, exp, "held");
  endtask

  task automatic verify_reset_state();
    check_strobe(ins_decoded, 1'b0, "after reset");
    check_error(dec_error, 1'b0, "after reset");
  endtask

  // every second nibble of group 0 except E
  task automatic decode_group_0x();
    nib_q_t q;
    for (int n = 0; n < 16; n++) begin
      if (n != 14) begin
        q.delete();
        q.push_back(4'h0);
        q.push_back(4'(n));
        run_instruction(q);
      end
    end
  endtask

  // P=n, load C hex, GOC, GONC, GOTO and GOSUB
  task automatic decode_operand_groups();
    for (int f = 2; f < 8; f++) begin
      repeat (3) run_instruction(random_ins(4'(f)));
    end
  endtask

  task automatic run_with_back_pressure();
    logic [3:0] first;
    use_stalls = 1'b1;
    repeat (16) begin
      first = 4'($urandom_range(7, 1));
      if (first == 4'h1) begin
        first = 4'h0;
      end
      run_instruction(random_ins(first));
    end
    use_stalls = 1'b0;
  endtask

  task automatic provoke_errors();
    nib_q_t q;
    apply_reset();
    accept_nibble(4'h8, '0);
    check_error(dec_error, 1'b1, "first nibble 8");
    // a valid instruction after the error stays ignored
    q = random_ins(4'h0);
    foreach (q[i]) begin
      accept_nibble(q[i], '0);
      check_error(dec_error, 1'b1, "nibble after the error");
      check_strobe(ins_decoded, 1'b0, "nibble after the error");
    end
    apply_reset();
    check_error(dec_error, 1'b0, "after the second reset");
    accept_nibble(4'h0, '0);
    check_error(dec_error, 1'b0, "group 0 prefix");
    accept_nibble(4'hE, '0);
    check_error(dec_error, 1'b1, "second nibble E");
    q = random_ins(4'h6);
    foreach (q[i]) begin
      accept_nibble(q[i], '0);
      check_error(dec_error, 1'b1, "nibble after 0E");
      check_strobe(ins_decoded, 1'b0, "nibble after 0E");
    end
  endtask

// File: tb_saturn_decoder.sv
/*
 * Saturn decoder testbench
 * feeds directed instruction streams, with and without back-pressure,
 * and checks decoded results against a model built from the opcode rules
 */

`timescale 1ns/1ps

`include "saturn_dec_macros.svh"

module tb_saturn_decoder import saturn_dec_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_IDLE     = 3;
  localparam int DONE_TIMEOUT = 8;
  // 3F with 16 digits plus two cycles of checking
  localparam int MAX_INS_CYCLES = 21;
  // 15 group 0 instructions, 18 with operands, 16 under back-pressure, error nibbles
  localparam int TOTAL_NIBBLES = (15 + 18 + 16) * MAX_INS_CYCLES + 16;
  localparam int WATCHDOG_NS =
    (TOTAL_NIBBLES * (MAX_IDLE + 1) + 3 * RESET_CYCLES) * CLK_PERIOD + 1000;

  typedef logic [`SAT_NIBBLE_W-1:0] nib_q_t[$];

  logic                     clk;
  logic                     reset;
  logic                     en_dec;
  logic                     stalled;
  logic [`SAT_ADDR_W-1:0]   pc;
  logic [`SAT_NIBBLE_W-1:0] nibble;
  logic                     ins_decoded;
  logic                     dec_error;
  dec_result_t              result;
  bit                       use_stalls;

  saturn_decoder UUT (
    .i_clk         (clk),
    .i_reset       (reset),
    .i_en_dec      (en_dec),
    .i_stalled     (stalled),
    .i_pc          (pc),
    .i_nibble      (nibble),
    .o_ins_decoded (ins_decoded),
    .o_dec_error   (dec_error),
    .o_result      (result)
  );

  `include "tb_saturn_decoder_tasks.svh"

  // flow bits from high to low are push pop set_xm set_carry carry_val test_carry en_intr
  function automatic op_fields_t make_op(input ins_kind_e kind, input alu_op_e alu,
                                         input logic [6:0] flow, input logic mode_dec);
    op_fields_t op;
    op.kind     = kind;
    op.alu_op   = alu;
    op.flow     = flow;
    op.mode_dec = mode_dec;
    return op;
  endfunction

  function automatic op_fields_t expected_op(input logic [3:0] first,
                                             input logic [3:0] second);
    if (first != 4'h0) begin
      case (first)
        4'h2:    return make_op(INS_SET_P, ALU_COPY, 7'b0000000, 1'b0);
        4'h3:    return make_op(INS_LOAD_C, ALU_COPY, 7'b0000000, 1'b0);
        4'h4:    return make_op(INS_JUMP, ALU_JMP_REL2, 7'b0000110, 1'b0);
        4'h5:    return make_op(INS_JUMP, ALU_JMP_REL2, 7'b0000010, 1'b0);
        4'h6:    return make_op(INS_JUMP, ALU_JMP_REL3, 7'b0000000, 1'b0);
        default: return make_op(INS_JUMP, ALU_JMP_REL3, 7'b1000000, 1'b0);
      endcase
    end
    // second nibble of group 0
    case (second)
      4'h0:       return make_op(INS_RTN, ALU_NONE, 7'b0110000, 1'b0);
      4'h1:       return make_op(INS_RTN, ALU_NONE, 7'b0100000, 1'b0);
      4'h2:       return make_op(INS_RTN, ALU_NONE, 7'b0101100, 1'b0);
      4'h3:       return make_op(INS_RTN, ALU_NONE, 7'b0101000, 1'b0);
      4'h4:       return make_op(INS_SET_MODE, ALU_NONE, 7'b0000000, 1'b0);
      4'h5:       return make_op(INS_SET_MODE, ALU_NONE, 7'b0000000, 1'b1);
      4'h6:       return make_op(INS_ALU, ALU_COPY, 7'b1000000, 1'b0);
      4'h7:       return make_op(INS_ALU, ALU_COPY, 7'b0100000, 1'b0);
      4'h8:       return make_op(INS_ALU, ALU_ZERO, 7'b0000000, 1'b0);
      4'h9, 4'hA: return make_op(INS_ALU, ALU_COPY, 7'b0000000, 1'b0);
      4'hB:       return make_op(INS_ALU, ALU_EXCH, 7'b0000000, 1'b0);
      4'hC:       return make_op(INS_ALU, ALU_INC, 7'b0000000, 1'b0);
      4'hD:       return make_op(INS_ALU, ALU_DEC, 7'b0000000, 1'b0);
      4'hF:       return make_op(INS_RTN, ALU_NONE, 7'b0100001, 1'b0);
      default:    return make_op(INS_NONE, ALU_NONE, 7'b0000000, 1'b0);
    endcase
  endfunction

  function automatic dec_result_t expected_result(input logic [`SAT_ADDR_W-1:0] addr,
                                                  input nib_q_t nibs);
    dec_result_t exp;
    int start;
    exp          = '0;
    exp.ins_addr = addr;
    exp.op       = expected_op(nibs[0], nibs[1]);
    // load C hex has its length nibble ahead of the digits
    start = (nibs[0] == 4'h3) ? 2 : 1;
    if (nibs[0] != 4'h0) begin
      exp.imm.imm_len = `SAT_CNT_W'(nibs.size() - start);
      for (int k = 0; k < nibs.size() - start; k++) begin
        exp.imm.imm_value[k*`SAT_NIBBLE_W +: `SAT_NIBBLE_W] = nibs[start + k];
      end
    end
    return exp;
  endfunction

  // one valid instruction of the group given by its first nibble
  function automatic nib_q_t random_ins(input logic [3:0] first);
    nib_q_t q;
    logic [3:0] n;
    int count;
    n     = 4'($urandom_range(15, 0));
    count = 0;
    q.push_back(first);
    case (first)
      4'h0:       q.push_back((n == 4'hE) ? 4'hF : n);
      4'h2:       count = 1;
      4'h3: begin
        q.push_back(n);
        count = n + 1;
      end
      4'h4, 4'h5: count = 2;
      default:    count = 3;
    endcase
    repeat (count) q.push_back(4'($urandom_range(15, 0)));
    return q;
  endfunction

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("watchdog expired, the decoder stopped making progress");
  end

  initial begin
    void'($urandom(55));
    use_stalls = 1'b0;
    reset      = 1'b1;
    en_dec     = 1'b0;
    stalled    = 1'b0;
    pc         = '0;
    nibble     = '0;
    apply_reset();
    verify_reset_state();
    decode_group_0x();
    decode_operand_groups();
    run_with_back_pressure();
    provoke_errors();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
saturn_dec_pkg.sv
dec_sequencer.sv
dec_op_gen.sv
imm_collector.sv
saturn_decoder.sv
tb_saturn_decoder.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_saturn_decoder -f vlog.f
	./obj_dir/Vtb_saturn_decoder | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
